/* verilog.f */
hw/miss_pkg.sv
hw/miss_entry_table.sv
hw/load_wait_queue.sv
hw/line_fetch.sv
hw/dcache_miss.sv
verification/dcache_miss_tb.sv

/* verification/miss_trace.txt */
// columns: issue cycle, port, byte address, lq index (all hex)
// a load returns its own word-aligned address as data
00 0 00001000 00
00 1 00001008 01
01 0 0000100c 02
02 1 00002004 03
03 0 00003000 04
04 1 00004008 05
05 0 00005004 06
06 1 00006000 07
08 0 00002008 08
90 1 0000100c 09
92 0 80a00014 0a
92 1 80a0001c 0b

/* verification/dcache_miss_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache_miss_tb import miss_pkg::*; ();

    localparam int load_ports = default_load_ports;
    localparam int miss_entries = default_miss_entries;
    localparam int wait_depth = default_wait_depth;
    localparam int bus_ids = 1 << id_w;
    localparam int max_loads = 1 << lq_idx_w;
    localparam int off_w = paddr_w - line_addr_w;
    // refill_ready held low for this many cycles after reset
    localparam int stall_cycles = 100;
    localparam int bus_worst = 40;

    logic clk;
    logic rst;
    logic [load_ports-1:0] ren;
    load_req_t req [load_ports];
    logic [load_ports-1:0] rfull;
    logic [load_ports-1:0] lq_en;
    load_resp_t resp [load_ports];
    logic ar_valid;
    ar_req_t ar;
    logic ar_ready;
    logic r_valid;
    r_beat_t r;
    logic refill_valid;
    refill_t refill;
    logic refill_ready;

    logic [31:0] trace_words [4*max_loads];
    int n_loads;
    int last_issue;
    int limit_cycles;
    bit trace_ready;
    int cyc;
    int returned;
    bit saw_stall_rfull;

    logic [paddr_w-1:0] ld_addr [max_loads];
    int ld_cycle [max_loads];
    bit ld_used [max_loads];
    int port_list [load_ports][max_loads];
    int port_cnt [load_ports];
    int port_next [load_ports];
    int replay_q [load_ports][max_loads];
    int replay_rd [load_ports];
    int replay_wr [load_ports];
    // accepted loads still owed a return, per port
    bit acc_out [load_ports][max_loads];
    int acc_seq [max_loads];
    int acc_cnt;
    // loads driven one and two edges ago, -1 when none
    int lq1 [load_ports];
    int lq2 [load_ports];

    // lines fetched and not yet refilled
    bit live_lines [logic [line_addr_w-1:0]];
    bit id_active [bus_ids];
    logic [paddr_w-1:0] id_addr [bus_ids];
    int id_beat [bus_ids];
    int ar_wait;

    dcache_miss #(
        .load_ports(load_ports),
        .miss_entries(miss_entries),
        .wait_depth(wait_depth),
        .bus_ids(bus_ids)
    ) dut_i (
        .clk(clk), .rst(rst), .ren(ren), .req(req),
        .rfull(rfull), .lq_en(lq_en), .resp(resp),
        .ar_valid(ar_valid), .ar(ar), .ar_ready(ar_ready),
        .r_valid(r_valid), .r(r),
        .refill_valid(refill_valid), .refill(refill), .refill_ready(refill_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [xlen-1:0] mem_word(input logic [paddr_w-1:0] addr);
        return {addr[paddr_w-1:2], 2'b00};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
            input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s, got %0h, expected %0h",
                $time, what, actual, expected);
            abort_run("a checked value was wrong");
        end
    endtask

    task automatic load_trace;
        int p;
        int lq;
        for (int i = 0; i < 4 * max_loads; i++) begin
            trace_words[i] = '1;
        end
        $readmemh("verification/miss_trace.txt", trace_words);
        while (n_loads < max_loads && trace_words[4*n_loads] != '1) begin
            p = int'(trace_words[4*n_loads+1]);
            lq = int'(trace_words[4*n_loads+3]);
            if (p >= load_ports || lq >= max_loads || ld_used[lq]) begin
                abort_run("trace line has a bad port or a repeated lq index");
            end else begin
                ld_used[lq] = 1'b1;
                ld_addr[lq] = trace_words[4*n_loads+2];
                ld_cycle[lq] = int'(trace_words[4*n_loads]);
                port_list[p][port_cnt[p]] = lq;
                port_cnt[p]++;
                if (ld_cycle[lq] > last_issue) begin
                    last_issue = ld_cycle[lq];
                end
            end
            n_loads++;
        end
        if (n_loads == 0) begin
            abort_run("trace file is missing or holds no loads");
        end
    endtask

    task automatic check_quiet;
        check_equal(ar_valid, 0, "ar_valid after reset");
        check_equal(refill_valid, 0, "refill_valid after reset");
        check_equal(rfull, 0, "rfull after reset");
        check_equal(lq_en, 0, "lq_en after reset");
    endtask

    task automatic observe_bus;
        logic [line_addr_w-1:0] la;
        if (ar_valid && ar_ready) begin
            la = ar.addr[paddr_w-1 -: line_addr_w];
            check_equal(ar.addr[off_w-1:0], 0, "ar address alignment");
            if (live_lines.exists(la)) begin
                abort_run("a second fetch was issued for a line still in flight");
            end else if (id_active[ar.id]) begin
                abort_run("a fetch reused a bus id that still owes beats");
            end else begin
                live_lines[la] = 1'b1;
                check_equal(live_lines.num() <= miss_entries, 1, "lines fetched at once");
                id_active[ar.id] = 1'b1;
                id_addr[ar.id] = ar.addr;
                id_beat[ar.id] = 0;
            end
        end
    endtask

    task automatic observe_refill;
        logic [paddr_w-1:0] base;
        if (refill_valid && refill_ready) begin
            base = {refill.line_addr, {off_w{1'b0}}};
            if (!live_lines.exists(refill.line_addr)) begin
                abort_run("refill of a line that was never fetched or was refilled twice");
            end else begin
                for (int w = 0; w < line_beats; w++) begin
                    check_equal(refill.data[w], mem_word(base + paddr_w'(4 * w)),
                        "refill word");
                end
                live_lines.delete(refill.line_addr);
            end
        end
    endtask

    // rfull now answers the load driven two edges ago
    task automatic handle_rfull;
        for (int p = 0; p < load_ports; p++) begin
            if (lq2[p] < 0) begin
                check_equal(rfull[p], 0, "rfull without a load");
            end else if (rfull[p]) begin
                replay_q[p][replay_wr[p] % max_loads] = lq2[p];
                replay_wr[p]++;
                if (cyc < stall_cycles) begin
                    saw_stall_rfull = 1'b1;
                end
            end else begin
                acc_out[p][lq2[p]] = 1'b1;
                acc_seq[lq2[p]] = acc_cnt;
                acc_cnt++;
            end
            lq2[p] = lq1[p];
        end
    endtask

    // lines may finish in any order, loads of one line keep their order
    task automatic observe_loads;
        int lq;
        logic [line_addr_w-1:0] la;
        bit older;
        for (int p = 0; p < load_ports; p++) begin
            if (lq_en[p]) begin
                lq = int'(resp[p].lq_idx);
                if (!acc_out[p][lq]) begin
                    abort_run("a load came back that was not outstanding on its port");
                end else begin
                    la = ld_addr[lq][paddr_w-1 -: line_addr_w];
                    older = 1'b0;
                    for (int o = 0; o < max_loads; o++) begin
                        if (acc_out[p][o] && acc_seq[o] < acc_seq[lq]
                                && ld_addr[o][paddr_w-1 -: line_addr_w] == la) begin
                            older = 1'b1;
                        end
                    end
                    if (older) begin
                        abort_run("a load passed an older load to the same line");
                    end else begin
                        acc_out[p][lq] = 1'b0;
                        check_equal(resp[p].data, mem_word(ld_addr[lq]), "load data");
                        returned++;
                    end
                end
            end
        end
    endtask

    // new trace loads go first, refused ones fill the gaps
    task automatic drive_loads;
        int lq;
        for (int p = 0; p < load_ports; p++) begin
            lq = -1;
            if (port_next[p] < port_cnt[p] && ld_cycle[port_list[p][port_next[p]]] <= cyc) begin
                lq = port_list[p][port_next[p]];
                port_next[p]++;
            end else if (replay_rd[p] != replay_wr[p]) begin
                lq = replay_q[p][replay_rd[p] % max_loads];
                replay_rd[p]++;
            end
            lq1[p] = lq;
            ren[p] <= lq >= 0;
            if (lq >= 0) begin
                req[p] <= '{addr: ld_addr[lq], lq_idx: lq_idx_w'(lq)};
            end
        end
    endtask

    task automatic drive_bus;
        int start;
        int pick;
        if (ar_valid && ar_ready) begin
            ar_ready <= 1'b0;
            ar_wait = -1;
        end else if (ar_valid) begin
            if (ar_wait < 0) begin
                ar_wait = $urandom_range(3);
            end
            if (ar_wait == 0) begin
                ar_ready <= 1'b1;
            end else begin
                ar_wait--;
            end
        end

        // random gaps, random choice among ids with beats owed
        pick = -1;
        r_valid <= 1'b0;
        if ($urandom_range(2) != 0) begin
            start = $urandom_range(bus_ids - 1);
            for (int i = 0; i < bus_ids; i++) begin
                if (pick < 0 && id_active[(start + i) % bus_ids]) begin
                    pick = (start + i) % bus_ids;
                end
            end
        end
        if (pick >= 0) begin
            r_valid <= 1'b1;
            r <= '{id: id_w'(pick),
                   data: mem_word(id_addr[pick] + paddr_w'(4 * id_beat[pick])),
                   last: id_beat[pick] == line_beats - 1};
            id_beat[pick]++;
            if (id_beat[pick] == line_beats) begin
                id_active[pick] = 1'b0;
            end
        end
    endtask

    task automatic drive_refill;
        if (cyc < stall_cycles) begin
            refill_ready <= 1'b0;
        end else begin
            refill_ready <= $urandom_range(3) != 0;
        end
    endtask

    task automatic step;
        @(posedge clk);
        observe_bus();
        observe_refill();
        handle_rfull();
        observe_loads();
        drive_loads();
        drive_bus();
        drive_refill();
        cyc++;
    endtask

    initial begin
        rst = 1'b0;
        ren = '0;
        req = '{default: '0};
        ar_ready = 1'b0;
        r_valid = 1'b0;
        r = '0;
        refill_ready = 1'b0;
        void'($urandom(32'h400bc88c));
        for (int p = 0; p < load_ports; p++) begin
            lq1[p] = -1;
            lq2[p] = -1;
        end
        ar_wait = -1;

        load_trace();
        limit_cycles = last_issue + stall_cycles + (n_loads + miss_entries) * bus_worst + 20;
        trace_ready = 1'b1;

        repeat (4) @(posedge clk);
        rst <= 1'b1;
        repeat (2) begin
            @(posedge clk);
            check_quiet();
        end

        while (returned < n_loads || live_lines.num() != 0) begin
            step();
        end
        // nothing extra may come back once the trace is done
        repeat (8) begin
            step();
        end
        check_equal(ar_valid, 0, "ar_valid after the last load");

        if (!saw_stall_rfull) begin
            abort_run("no load was refused while refill was held off");
        end else begin
            $display("No errors");
            $finish;
        end
    end

    initial begin
        wait (trace_ready);
        repeat (limit_cycles) @(posedge clk);
        abort_run("timeout, the trace did not complete in the allowed cycles");
    end

endmodule

`default_nettype wire

/* hw/dcache_miss.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache_miss import miss_pkg::*; #(
    parameter int load_ports = default_load_ports,
    parameter int miss_entries = default_miss_entries,
    parameter int wait_depth = default_wait_depth,
    parameter int bus_ids = 1 << id_w
) (
    input wire clk,
    input wire rst,
    input wire [load_ports-1:0] ren,
    input wire load_req_t req [load_ports],
    output logic [load_ports-1:0] rfull,
    output logic [load_ports-1:0] lq_en,
    output load_resp_t resp [load_ports],
    output logic ar_valid,
    output ar_req_t ar,
    input wire ar_ready,
    input wire r_valid,
    input wire r_beat_t r,
    output logic refill_valid,
    output refill_t refill,
    input wire refill_ready
);
    localparam int idx_w = $clog2(miss_entries);

    logic [load_ports-1:0] accept;
    logic [load_ports-1:0] wait_full;
    logic [idx_w-1:0] entry_idx [load_ports];
    logic [miss_entries-1:0] waiting;
    logic [miss_entries-1:0] pending;
    logic [miss_entries-1:0] line_ready;
    logic [line_addr_w-1:0] line_addr [miss_entries];
    logic fetch_start;
    logic [idx_w-1:0] fetch_idx;
    logic data_ready;
    logic [idx_w-1:0] ready_idx;
    line_t line [miss_entries];

    dcache_miss_entry_table #(
        .load_ports(load_ports),
        .miss_entries(miss_entries)
    ) entry_table_i (
        .clk(clk), .rst(rst), .ren(ren), .req(req),
        .wait_full(wait_full), .waiting(waiting),
        .fetch_start(fetch_start), .fetch_idx(fetch_idx),
        .data_ready(data_ready), .ready_idx(ready_idx),
        .refill_ready(refill_ready), .line_data(line),
        .accept(accept), .entry_idx(entry_idx),
        .pending(pending), .line_ready(line_ready), .line_addr(line_addr),
        .rfull(rfull), .refill_valid(refill_valid), .refill(refill)
    );

    load_wait_queue #(
        .load_ports(load_ports),
        .miss_entries(miss_entries),
        .wait_depth(wait_depth)
    ) wait_queue_i (
        .clk(clk), .rst(rst), .accept(accept), .entry_idx(entry_idx), .req(req),
        .line_ready(line_ready), .line(line),
        .wait_full(wait_full), .waiting(waiting), .lq_en(lq_en), .resp(resp)
    );

    line_fetch #(
        .miss_entries(miss_entries),
        .bus_ids(bus_ids)
    ) line_fetch_i (
        .clk(clk), .rst(rst), .pending(pending), .line_addr(line_addr),
        .ar_valid(ar_valid), .ar(ar), .ar_ready(ar_ready),
        .r_valid(r_valid), .r(r),
        .fetch_start(fetch_start), .fetch_idx(fetch_idx),
        .data_ready(data_ready), .ready_idx(ready_idx), .line(line)
    );

endmodule

`default_nettype wire

/* hw/line_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

module line_fetch import miss_pkg::*; #(
    parameter int miss_entries = default_miss_entries,
    parameter int bus_ids = 1 << id_w
) (
    input wire clk,
    input wire rst,
    input wire [miss_entries-1:0] pending,
    input wire [line_addr_w-1:0] line_addr [miss_entries],
    output logic ar_valid,
    output ar_req_t ar,
    input wire ar_ready,
    input wire r_valid,
    input wire r_beat_t r,
    output logic fetch_start,
    output logic [$clog2(miss_entries)-1:0] fetch_idx,
    output logic data_ready,
    output logic [$clog2(miss_entries)-1:0] ready_idx,
    output line_t line [miss_entries]
);
    localparam int idx_w = $clog2(miss_entries);

    typedef enum logic {st_idle, st_req} ar_state_e;

    ar_state_e ar_state;
    logic [bus_ids-1:0] id_busy;
    logic [idx_w-1:0] id_map [bus_ids];
    logic [offset_w-1:0] beat_cnt [bus_ids];
    logic [idx_w-1:0] pick_idx;
    logic [idx_w-1:0] beat_idx;
    logic [id_w-1:0] free_id;
    logic issue;

    always_comb begin
        pick_idx = '0;
        for (int e = miss_entries - 1; e >= 0; e--) begin
            if (pending[e]) begin
                pick_idx = idx_w'(e);
            end
        end
        free_id = '0;
        for (int b = bus_ids - 1; b >= 0; b--) begin
            if (!id_busy[b]) begin
                free_id = id_w'(b);
            end
        end
    end

    assign issue = ar_state == st_idle && |pending && !(&id_busy);
    assign fetch_start = ar_valid && ar_ready;
    assign beat_idx = id_map[r.id];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ar_state <= st_idle;
            ar_valid <= 1'b0;
            id_busy <= '0;
            data_ready <= 1'b0;
            beat_cnt <= '{default: '0};
        end else begin
            data_ready <= r_valid && r.last;
            if (r_valid) begin
                beat_cnt[r.id] <= r.last ? '0 : beat_cnt[r.id] + 1'b1;
            end
            // id goes back to the pool with its last beat
            if (r_valid && r.last) begin
                id_busy[r.id] <= 1'b0;
            end
            case (ar_state)
                st_idle: begin
                    if (issue) begin
                        ar_valid <= 1'b1;
                        id_busy[free_id] <= 1'b1;
                        ar_state <= st_req;
                    end
                end
                st_req: begin
                    if (ar_ready) begin
                        ar_valid <= 1'b0;
                        ar_state <= st_idle;
                    end
                end
                default: ar_state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        ready_idx <= beat_idx;
        if (issue) begin
            ar.id <= free_id;
            ar.addr <= {line_addr[pick_idx], {(paddr_w - line_addr_w){1'b0}}};
            fetch_idx <= pick_idx;
            id_map[free_id] <= pick_idx;
        end
        if (r_valid) begin
            line[beat_idx][beat_cnt[r.id]] <= r.data;
        end
    end

    assert property (@(posedge clk) disable iff (!rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar));

    // beats only for ids with a request outstanding
    assert property (@(posedge clk) disable iff (!rst) r_valid |-> id_busy[r.id]);

endmodule

`default_nettype wire

/* hw/load_wait_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module load_wait_queue import miss_pkg::*; #(
    parameter int load_ports = default_load_ports,
    parameter int miss_entries = default_miss_entries,
    parameter int wait_depth = default_wait_depth
) (
    input wire clk,
    input wire rst,
    input wire [load_ports-1:0] accept,
    input wire [$clog2(miss_entries)-1:0] entry_idx [load_ports],
    input wire load_req_t req [load_ports],
    input wire [miss_entries-1:0] line_ready,
    input wire line_t line [miss_entries],
    output logic [load_ports-1:0] wait_full,
    output logic [miss_entries-1:0] waiting,
    output logic [load_ports-1:0] lq_en,
    output load_resp_t resp [load_ports]
);
    localparam int idx_w = $clog2(miss_entries);
    localparam int slot_w = $clog2(wait_depth);

    typedef struct packed {
        logic valid;
        logic [idx_w-1:0] idx;
        logic [offset_w-1:0] offset;
        logic [lq_idx_w-1:0] lq_idx;
    } wait_slot_t;

    // slot 0 holds the oldest load of a port
    wait_slot_t [wait_depth-1:0] slots [load_ports];
    wait_slot_t [wait_depth-1:0] slots_next [load_ports];
    logic [load_ports-1:0] pop;
    logic [slot_w-1:0] pop_slot [load_ports];

    always_comb begin
        logic placed;
        waiting = '0;
        for (int p = 0; p < load_ports; p++) begin
            wait_full[p] = slots[p][wait_depth-1].valid;
            pop[p] = 1'b0;
            pop_slot[p] = '0;
            for (int s = wait_depth - 1; s >= 0; s--) begin
                if (slots[p][s].valid && line_ready[slots[p][s].idx]) begin
                    pop[p] = 1'b1;
                    pop_slot[p] = slot_w'(s);
                end
                if (slots[p][s].valid) begin
                    waiting[slots[p][s].idx] = 1'b1;
                end
            end

            // close the gap left by the returned load
            slots_next[p] = slots[p];
            if (pop[p]) begin
                for (int s = 0; s < wait_depth - 1; s++) begin
                    if (s >= pop_slot[p]) begin
                        slots_next[p][s] = slots[p][s+1];
                    end
                end
                slots_next[p][wait_depth-1] = '0;
            end

            placed = 1'b0;
            for (int s = 0; s < wait_depth; s++) begin
                if (accept[p] && !placed && !slots_next[p][s].valid) begin
                    slots_next[p][s].valid = 1'b1;
                    slots_next[p][s].idx = entry_idx[p];
                    slots_next[p][s].offset = req[p].addr[offset_w+1:2];
                    slots_next[p][s].lq_idx = req[p].lq_idx;
                    placed = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            slots <= '{default: '0};
            lq_en <= '0;
        end else begin
            slots <= slots_next;
            lq_en <= pop;
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < load_ports; p++) begin
            resp[p].data <= line[slots[p][pop_slot[p]].idx][slots[p][pop_slot[p]].offset];
            resp[p].lq_idx <= slots[p][pop_slot[p]].lq_idx;
        end
    end

    for (genvar p = 0; p < load_ports; p++) begin : g_chk
        assert property (@(posedge clk) disable iff (!rst) accept[p] |-> !wait_full[p]);
    end

endmodule

`default_nettype wire

/* hw/miss_entry_table.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache_miss_entry_table import miss_pkg::*; #(
    parameter int load_ports = default_load_ports,
    parameter int miss_entries = default_miss_entries
) (
    input wire clk,
    input wire rst,
    input wire [load_ports-1:0] ren,
    input wire load_req_t req [load_ports],
    input wire [load_ports-1:0] wait_full,
    input wire [miss_entries-1:0] waiting,
    input wire fetch_start,
    input wire [$clog2(miss_entries)-1:0] fetch_idx,
    input wire data_ready,
    input wire [$clog2(miss_entries)-1:0] ready_idx,
    input wire refill_ready,
    input wire line_t line_data [miss_entries],
    output logic [load_ports-1:0] accept,
    output logic [$clog2(miss_entries)-1:0] entry_idx [load_ports],
    output logic [miss_entries-1:0] pending,
    output logic [miss_entries-1:0] line_ready,
    output logic [line_addr_w-1:0] line_addr [miss_entries],
    output logic [load_ports-1:0] rfull,
    output logic refill_valid,
    output refill_t refill
);
    localparam int idx_w = $clog2(miss_entries);

    typedef enum logic [1:0] {st_pend, st_flight, st_ready, st_done} entry_state_e;

    logic [miss_entries-1:0] valid;
    entry_state_e state [miss_entries];
    logic [miss_entries-1:0] retire;
    logic [miss_entries-1:0] ready_vec;
    logic [load_ports-1:0] alloc;
    logic [idx_w-1:0] alloc_idx [load_ports];
    logic [idx_w-1:0] refill_idx;
    logic [idx_w-1:0] hold_idx;
    logic hold;

    always_comb begin
        for (int e = 0; e < miss_entries; e++) begin
            retire[e] = valid[e] && state[e] == st_done && !waiting[e];
            pending[e] = valid[e] && state[e] == st_pend;
            ready_vec[e] = valid[e] && state[e] == st_ready;
            line_ready[e] = valid[e] && (state[e] == st_ready || state[e] == st_done);
        end
    end

    // merge into a resident line, else into an earlier port's new line, else allocate
    always_comb begin
        logic [miss_entries-1:0] free_left;
        logic [line_addr_w-1:0] req_line;
        logic found;
        free_left = ~valid;
        for (int i = 0; i < load_ports; i++) begin
            req_line = req[i].addr[paddr_w-1 -: line_addr_w];
            found = 1'b0;
            entry_idx[i] = '0;
            alloc[i] = 1'b0;
            alloc_idx[i] = '0;
            for (int e = 0; e < miss_entries; e++) begin
                if (valid[e] && !retire[e] && line_addr[e] == req_line) begin
                    found = 1'b1;
                    entry_idx[i] = idx_w'(e);
                end
            end
            for (int j = 0; j < i; j++) begin
                if (alloc[j] && req[j].addr[paddr_w-1 -: line_addr_w] == req_line) begin
                    found = 1'b1;
                    entry_idx[i] = alloc_idx[j];
                end
            end
            if (ren[i] && !wait_full[i] && !found) begin
                for (int e = miss_entries - 1; e >= 0; e--) begin
                    if (free_left[e]) begin
                        alloc[i] = 1'b1;
                        alloc_idx[i] = idx_w'(e);
                    end
                end
                if (alloc[i]) begin
                    found = 1'b1;
                    entry_idx[i] = alloc_idx[i];
                    free_left[alloc_idx[i]] = 1'b0;
                end
            end
            accept[i] = ren[i] && !wait_full[i] && found;
        end
    end

    // lowest ready entry, held while the cache stalls
    always_comb begin
        refill_idx = hold_idx;
        if (!hold) begin
            refill_idx = '0;
            for (int e = miss_entries - 1; e >= 0; e--) begin
                if (ready_vec[e]) begin
                    refill_idx = idx_w'(e);
                end
            end
        end
    end

    assign refill_valid = |ready_vec;
    assign refill.line_addr = line_addr[refill_idx];
    assign refill.data = line_data[refill_idx];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid <= '0;
            rfull <= '0;
            hold <= 1'b0;
            state <= '{default: st_pend};
        end else begin
            rfull <= ren & ~accept;
            hold <= refill_valid && !refill_ready;
            for (int e = 0; e < miss_entries; e++) begin
                if (retire[e]) begin
                    valid[e] <= 1'b0;
                end
            end
            if (fetch_start) begin
                state[fetch_idx] <= st_flight;
            end
            if (data_ready) begin
                state[ready_idx] <= st_ready;
            end
            if (refill_valid && refill_ready) begin
                state[refill_idx] <= st_done;
            end
            for (int i = 0; i < load_ports; i++) begin
                if (alloc[i]) begin
                    valid[alloc_idx[i]] <= 1'b1;
                    state[alloc_idx[i]] <= st_pend;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        hold_idx <= refill_idx;
        for (int i = 0; i < load_ports; i++) begin
            if (alloc[i]) begin
                line_addr[alloc_idx[i]] <= req[i].addr[paddr_w-1 -: line_addr_w];
            end
        end
    end

    // one entry per line
    for (genvar a = 0; a < miss_entries; a++) begin : g_uniq_a
        for (genvar b = a + 1; b < miss_entries; b++) begin : g_uniq_b
            assert property (@(posedge clk) disable iff (!rst)
                !(valid[a] && valid[b] && line_addr[a] == line_addr[b]));
        end
    end

endmodule

`default_nettype wire

/* hw/miss_pkg.sv */
`default_nettype none

package miss_pkg;

    localparam int paddr_w = 32;
    localparam int xlen = 32;
    localparam int line_beats = 4;
    localparam int offset_w = 2;
    localparam int line_addr_w = 28;
    localparam int lq_idx_w = 5;
    localparam int id_w = 1;

    localparam int default_load_ports = 2;
    localparam int default_miss_entries = 4;
    localparam int default_wait_depth = 4;

    typedef logic [line_beats-1:0][xlen-1:0] line_t;

    typedef struct packed {
        logic [paddr_w-1:0] addr;
        logic [lq_idx_w-1:0] lq_idx;
    } load_req_t;

    typedef struct packed {
        logic [xlen-1:0] data;
        logic [lq_idx_w-1:0] lq_idx;
    } load_resp_t;

    // line aligned read request
    typedef struct packed {
        logic [id_w-1:0] id;
        logic [paddr_w-1:0] addr;
    } ar_req_t;

    typedef struct packed {
        logic [id_w-1:0] id;
        logic [xlen-1:0] data;
        logic last;
    } r_beat_t;

    typedef struct packed {
        logic [line_addr_w-1:0] line_addr;
        line_t data;
    } refill_t;

endpackage

`default_nettype wire
